//--- hw/cache_pkg.sv
package cache_pkg;

  // --------------------------------------------------
  // Cache geometry
  // --------------------------------------------------
  localparam int unsigned LINE_SIZE  = 4;     // Bytes per line.
  localparam int unsigned CACHE_SIZE = 1024;  // Capacity in bytes.
  localparam int unsigned LINE_NUM   = CACHE_SIZE / LINE_SIZE;
  localparam int unsigned OFFSET_W   = $clog2(LINE_SIZE);
  localparam int unsigned SET_W      = $clog2(LINE_NUM);
  localparam int unsigned TAG_W      = 32 - SET_W - OFFSET_W;

  // --------------------------------------------------
  // Enums
  // --------------------------------------------------
  typedef enum logic {
    OP_LOAD,
    OP_STORE
  } cache_op_e;

  typedef enum logic [2:0] {
    ST_INIT,    // Invalidate sweep after reset.
    ST_IDLE,
    ST_LOOKUP,
    ST_WB,      // Dirty victim goes out to memory.
    ST_REFILL,  // Waiting for the load data.
    ST_FILL,
    ST_RESP
  } ctrl_state_e;

  // --------------------------------------------------
  // Bundles
  // --------------------------------------------------
  typedef struct packed {
    cache_op_e   op;
    logic [31:0] addr;
    logic [31:0] wdata;
  } cpu_req_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic        hit;
  } cpu_resp_t;

  typedef struct packed {
    logic [31:0] addr;   // Always line aligned.
    logic [31:0] wdata;
  } mem_req_t;

  // One word of the tag RAM. The pad keeps the entry a full 32-bit word.
  typedef struct packed {
    logic [7:0]       pad;
    logic             dirty;
    logic             valid;
    logic [TAG_W-1:0] tag;
  } tag_entry_t;

  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] data;
    logic        valid;
    logic        dirty;
  } line_write_t;

endpackage

//--- hw/bram.sv
`timescale 1ns/1ps

module bram #(
  parameter int DATA_WIDTH = 32,
  parameter int DEPTH      = 256
) (
  input  logic                     clk,
  input  logic [$clog2(DEPTH)-1:0] addr,
  input  logic                     wen,
  input  logic [DATA_WIDTH-1:0]    din,
  output logic [DATA_WIDTH-1:0]    dout
);

  logic [DATA_WIDTH-1:0] mem [DEPTH];

  // Read returns the old contents when the same address is written.
  always_ff @(posedge clk) begin
    if (wen) begin
      mem[addr] <= din;
    end
    dout <= mem[addr];
  end

endmodule

//--- hw/direct_map.sv
`timescale 1ns/1ps

module direct_map (
  input  logic                        clk,
  input  logic [31:0]                 lookup_addr,
  input  logic                        wr_en,
  input  cache_pkg::line_write_t      wr,
  output logic                        hit,
  output logic                        valid,
  output logic                        dirty,
  output logic [cache_pkg::TAG_W-1:0] victim_tag,
  output logic [31:0]                 rdata
);

  logic [cache_pkg::SET_W-1:0] lookup_set;
  logic [cache_pkg::SET_W-1:0] wr_set;
  logic [cache_pkg::SET_W-1:0] ram_addr;
  logic [cache_pkg::TAG_W-1:0] lookup_tag;
  logic [cache_pkg::TAG_W-1:0] wr_tag;
  logic [cache_pkg::TAG_W-1:0] lookup_tag_q;

  cache_pkg::tag_entry_t tag_din;
  cache_pkg::tag_entry_t tag_dout;
  logic [cache_pkg::LINE_SIZE*8-1:0] data_dout;

  // --------------------------------------------------
  // Address split
  // --------------------------------------------------
  // The low OFFSET_W bits select a byte inside the line and play no part here.
  assign lookup_set = lookup_addr[cache_pkg::OFFSET_W +: cache_pkg::SET_W];
  assign lookup_tag = lookup_addr[cache_pkg::OFFSET_W + cache_pkg::SET_W +: cache_pkg::TAG_W];
  assign wr_set     = wr.addr[cache_pkg::OFFSET_W +: cache_pkg::SET_W];
  assign wr_tag     = wr.addr[cache_pkg::OFFSET_W + cache_pkg::SET_W +: cache_pkg::TAG_W];

  assign ram_addr = wr_en ? wr_set : lookup_set;  // A write steals the port.

  assign tag_din = '{pad: '0, dirty: wr.dirty, valid: wr.valid, tag: wr_tag};

  // --------------------------------------------------
  // Arrays
  // --------------------------------------------------
  bram #(
    .DATA_WIDTH(cache_pkg::LINE_SIZE * 8),
    .DEPTH     (cache_pkg::LINE_NUM)
  ) cached_data (
    .clk (clk),
    .addr(ram_addr),
    .wen (wr_en),
    .din (wr.data),
    .dout(data_dout)
  );

  bram #(
    .DATA_WIDTH($bits(cache_pkg::tag_entry_t)),
    .DEPTH     (cache_pkg::LINE_NUM)
  ) valid_and_tag (
    .clk (clk),
    .addr(ram_addr),
    .wen (wr_en),
    .din (tag_din),
    .dout(tag_dout)
  );

  // The RAM answers one cycle later, so the tag to compare has to wait too.
  always_ff @(posedge clk) begin
    lookup_tag_q <= lookup_tag;
  end

  assign valid      = tag_dout.valid;
  assign dirty      = tag_dout.dirty;
  assign victim_tag = tag_dout.tag;
  assign hit        = tag_dout.valid && (tag_dout.tag == lookup_tag_q);
  assign rdata      = data_dout;

endmodule

//--- hw/cache_ctrl.sv
`timescale 1ns/1ps

module cache_ctrl (
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic                        req,
  input  cache_pkg::cpu_req_t         req_data,
  output logic                        busy,
  output logic                        resp_valid,
  output cache_pkg::cpu_resp_t        resp_data,
  output logic [31:0]                 lookup_addr,
  output logic                        wr_en,
  output cache_pkg::line_write_t      wr,
  input  logic                        hit,
  input  logic                        valid,
  input  logic                        dirty,
  input  logic [cache_pkg::TAG_W-1:0] victim_tag,
  input  logic [31:0]                 rdata,
  output logic                        mem_rd,
  output logic                        mem_wr,
  output cache_pkg::mem_req_t         mem_req,
  input  logic                        mem_ack,
  input  logic [31:0]                 mem_rdata
);

  cache_pkg::ctrl_state_e state;
  cache_pkg::ctrl_state_e state_d;

  logic [cache_pkg::SET_W-1:0] init_cnt;
  logic                        reread;

  cache_pkg::cpu_req_t req_q;
  logic                hit_q;
  logic [31:0]         rdata_q;

  logic accept;       // Take a new request from the core.
  logic take_lookup;  // Keep the lookup result.
  logic take_mem;     // Keep the refill word.
  logic issue_wr;
  logic issue_rd;

  logic        is_store;
  logic        open_for_req;
  logic [31:0] line_addr;
  logic [31:0] wb_addr;
  logic [31:0] init_addr;
  logic [31:0] line_data;

  // --------------------------------------------------
  // Address and data helpers
  // --------------------------------------------------
  assign is_store     = (req_q.op == cache_pkg::OP_STORE);
  assign open_for_req = (state == cache_pkg::ST_IDLE) || (state == cache_pkg::ST_RESP);

  assign line_addr = {req_q.addr[31:cache_pkg::OFFSET_W], {cache_pkg::OFFSET_W{1'b0}}};

  // The victim shares the set of the request, only its tag differs.
  assign wb_addr = {victim_tag,
                    req_q.addr[cache_pkg::OFFSET_W +: cache_pkg::SET_W],
                    {cache_pkg::OFFSET_W{1'b0}}};

  assign init_addr = {{cache_pkg::TAG_W{1'b0}}, init_cnt, {cache_pkg::OFFSET_W{1'b0}}};

  // A store brings its own word. A load gets it from the cache or from memory.
  assign line_data = is_store ? req_q.wdata : rdata_q;

  // --------------------------------------------------
  // Next state
  // --------------------------------------------------
  always_comb begin
    state_d     = state;
    accept      = 1'b0;
    take_lookup = 1'b0;
    take_mem    = 1'b0;
    issue_wr    = 1'b0;
    issue_rd    = 1'b0;
    case (state)
      cache_pkg::ST_INIT: begin
        if (&init_cnt) begin
          state_d = cache_pkg::ST_IDLE;
        end
      end
      cache_pkg::ST_IDLE: begin
        if (req) begin
          accept  = 1'b1;
          state_d = cache_pkg::ST_LOOKUP;
        end
      end
      cache_pkg::ST_LOOKUP: begin
        // After a store hit the RAM port was busy, so the read is done again.
        if (!reread) begin
          take_lookup = 1'b1;
          if (hit) begin
            state_d = cache_pkg::ST_RESP;
          end else if (valid && dirty) begin
            issue_wr = 1'b1;
            state_d  = cache_pkg::ST_WB;
          end else if (!is_store) begin
            issue_rd = 1'b1;
            state_d  = cache_pkg::ST_REFILL;
          end else begin
            state_d = cache_pkg::ST_FILL;
          end
        end
      end
      cache_pkg::ST_WB: begin
        if (mem_ack) begin
          if (is_store) begin
            state_d = cache_pkg::ST_FILL;  // Whole-line store, no refill.
          end else begin
            issue_rd = 1'b1;
            state_d  = cache_pkg::ST_REFILL;
          end
        end
      end
      cache_pkg::ST_REFILL: begin
        if (mem_ack) begin
          take_mem = 1'b1;
          state_d  = cache_pkg::ST_FILL;
        end
      end
      cache_pkg::ST_FILL: begin
        state_d = cache_pkg::ST_RESP;
      end
      cache_pkg::ST_RESP: begin
        if (req) begin
          accept  = 1'b1;
          state_d = cache_pkg::ST_LOOKUP;
        end else begin
          state_d = cache_pkg::ST_IDLE;
        end
      end
      default: begin
        state_d = cache_pkg::ST_INIT;
      end
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= cache_pkg::ST_INIT;
      init_cnt <= '0;
      reread   <= 1'b0;
      mem_rd   <= 1'b0;
      mem_wr   <= 1'b0;
    end else begin
      state  <= state_d;
      mem_rd <= issue_rd;  // One-cycle pulses.
      mem_wr <= issue_wr;
      reread <= accept && wr_en;
      if (state == cache_pkg::ST_INIT) begin
        init_cnt <= init_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      req_q <= req_data;
    end
    if (take_lookup) begin
      hit_q   <= hit;
      rdata_q <= rdata;
    end
    if (take_mem) begin
      rdata_q <= mem_rdata;
    end
    if (issue_wr) begin
      mem_req <= '{addr: wb_addr, wdata: rdata};
    end
    if (issue_rd) begin
      mem_req.addr <= line_addr;
    end
  end

  // --------------------------------------------------
  // Outputs
  // --------------------------------------------------
  assign busy        = !open_for_req;
  assign resp_valid  = (state == cache_pkg::ST_RESP);
  assign resp_data   = '{rdata: line_data, hit: hit_q};
  assign lookup_addr = open_for_req ? req_data.addr : req_q.addr;

  assign wr_en = (state == cache_pkg::ST_INIT) ||
                 (state == cache_pkg::ST_FILL) ||
                 ((state == cache_pkg::ST_RESP) && is_store && hit_q);

  // The sweep writes invalid entries. Otherwise the line of the latched request is written.
  always_comb begin
    wr.addr  = (state == cache_pkg::ST_INIT) ? init_addr : line_addr;
    wr.data  = (state == cache_pkg::ST_INIT) ? '0 : line_data;
    wr.valid = (state != cache_pkg::ST_INIT);
    wr.dirty = (state != cache_pkg::ST_INIT) && is_store;
  end

endmodule

//--- hw/cache_top.sv
`timescale 1ns/1ps

module cache_top (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 req,
  input  cache_pkg::cpu_req_t  req_data,
  output logic                 busy,
  output logic                 resp_valid,
  output cache_pkg::cpu_resp_t resp_data,
  output logic                 mem_rd,
  output logic                 mem_wr,
  output cache_pkg::mem_req_t  mem_req,
  input  logic                 mem_ack,
  input  logic [31:0]          mem_rdata
);

  // --------------------------------------------------
  // Controller to lookup block
  // --------------------------------------------------
  logic [31:0]                 lookup_addr;
  logic                        wr_en;
  cache_pkg::line_write_t      wr;
  logic                        hit;
  logic                        valid;
  logic                        dirty;
  logic [cache_pkg::TAG_W-1:0] victim_tag;
  logic [31:0]                 rdata;

  cache_ctrl u_ctrl (
    .clk        (clk),
    .arst_n     (arst_n),
    .req        (req),
    .req_data   (req_data),
    .busy       (busy),
    .resp_valid (resp_valid),
    .resp_data  (resp_data),
    .lookup_addr(lookup_addr),
    .wr_en      (wr_en),
    .wr         (wr),
    .hit        (hit),
    .valid      (valid),
    .dirty      (dirty),
    .victim_tag (victim_tag),
    .rdata      (rdata),
    .mem_rd     (mem_rd),
    .mem_wr     (mem_wr),
    .mem_req    (mem_req),
    .mem_ack    (mem_ack),
    .mem_rdata  (mem_rdata)
  );

  direct_map u_map (
    .clk        (clk),
    .lookup_addr(lookup_addr),
    .wr_en      (wr_en),
    .wr         (wr),
    .hit        (hit),
    .valid      (valid),
    .dirty      (dirty),
    .victim_tag (victim_tag),
    .rdata      (rdata)
  );

endmodule

//--- verification/tb_cache.sv
`timescale 1ns/1ps

module tb_cache;

  localparam int          CLK_PERIOD  = 40;
  localparam int          RAND_OPS    = 2000;
  localparam int          WATCHDOG_NS = 2300 * 30 * CLK_PERIOD + (256 + 10) * CLK_PERIOD;
  localparam logic [31:0] ADDR_X      = 32'h0000_1234;
  localparam logic [31:0] ADDR_A      = 32'h0000_2040;
  localparam logic [31:0] ADDR_B      = 32'h0000_2440;  // Same set as ADDR_A, next tag.
  localparam logic [31:0] RAND_BASE   = 32'h0008_0000;

  typedef struct packed {
    logic        hit;
    logic [31:0] rdata;
    logic        wb;
    logic [31:0] wb_addr;
    logic [31:0] wb_data;
    logic        rd;
    logic [31:0] rd_addr;
  } expect_t;

  logic                 clk;
  logic                 arst_n;
  logic                 req;
  cache_pkg::cpu_req_t  req_data;
  logic                 busy;
  logic                 resp_valid;
  cache_pkg::cpu_resp_t resp_data;
  logic                 mem_rd;
  logic                 mem_wr;
  cache_pkg::mem_req_t  mem_req;
  logic                 mem_ack;
  logic [31:0]          mem_rdata;

  integer               seed = 54722;
  int                   err_cnt = 0;
  int                   tests_passed = 0;
  int                   tests_failed = 0;
  int                   rd_cnt = 0;
  int                   wr_cnt = 0;
  int                   last_lat = 0;
  expect_t              exp_q = '0;
  cache_pkg::cpu_resp_t last_resp;

  // Shadow copy of the cache and of the memory behind it.
  bit                          sh_valid [cache_pkg::LINE_NUM];
  bit                          sh_dirty [cache_pkg::LINE_NUM];
  logic [cache_pkg::TAG_W-1:0] sh_tag   [cache_pkg::LINE_NUM];
  logic [31:0]                 sh_data  [cache_pkg::LINE_NUM];
  logic [31:0]                 ref_mem  [logic [31:0]];
  logic [31:0]                 mem_model [logic [31:0]];

  cache_top uut (
    .clk       (clk),
    .arst_n    (arst_n),
    .req       (req),
    .req_data  (req_data),
    .busy      (busy),
    .resp_valid(resp_valid),
    .resp_data (resp_data),
    .mem_rd    (mem_rd),
    .mem_wr    (mem_wr),
    .mem_req   (mem_req),
    .mem_ack   (mem_ack),
    .mem_rdata (mem_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // --------------------------------------------------
  // Reference model
  // --------------------------------------------------
  function automatic logic [31:0] unwritten_word(input logic [31:0] addr);
    return addr ^ 32'hA5A5_0000;
  endfunction

  function automatic expect_t predict_access(input cache_pkg::cache_op_e op,
                                             input logic [31:0] addr,
                                             input logic [31:0] wdata);
    expect_t                     e;
    logic [cache_pkg::SET_W-1:0] set;
    logic [cache_pkg::TAG_W-1:0] tag;
    logic [31:0]                 line;
    e    = '0;
    set  = addr[cache_pkg::OFFSET_W +: cache_pkg::SET_W];
    tag  = addr[31 -: cache_pkg::TAG_W];
    line = {addr[31:cache_pkg::OFFSET_W], {cache_pkg::OFFSET_W{1'b0}}};
    e.hit = sh_valid[set] && (sh_tag[set] == tag);
    if (!e.hit) begin
      if (sh_valid[set] && sh_dirty[set]) begin  // Victim goes back first.
        e.wb      = 1'b1;
        e.wb_addr = {sh_tag[set], set, {cache_pkg::OFFSET_W{1'b0}}};
        e.wb_data = sh_data[set];
        ref_mem[e.wb_addr] = e.wb_data;
      end
      sh_valid[set] = 1'b1;
      sh_dirty[set] = 1'b0;
      sh_tag[set]   = tag;
      if (op == cache_pkg::OP_LOAD) begin
        e.rd         = 1'b1;
        e.rd_addr    = line;
        sh_data[set] = ref_mem.exists(line) ? ref_mem[line] : unwritten_word(line);
      end
    end
    if (op == cache_pkg::OP_STORE) begin
      sh_data[set]  = wdata;
      sh_dirty[set] = 1'b1;
    end
    e.rdata = sh_data[set];
    return e;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] want, input logic [31:0] addr);
    $display("Error: %s = %h, expected %h (addr %h)", name, got, want, addr);
    err_cnt++;
  endtask

  task automatic close_test(input string name, input int errs_before);
    if (err_cnt == errs_before) begin
      tests_passed++;
      $display("Test %s: passed", name);
    end else begin
      tests_failed++;
      $display("Test %s: failed with %0d errors", name, err_cnt - errs_before);
    end
  endtask

  // Issues one request and checks the response against the reference model.
  task automatic run_access(input cache_pkg::cache_op_e op, input logic [31:0] addr,
                            input logic [31:0] wdata);
    expect_t e;
    while (busy !== 1'b0) @(negedge clk);
    e              = predict_access(op, addr, wdata);
    exp_q          = e;
    rd_cnt         = 0;
    wr_cnt         = 0;
    req            = 1'b1;
    req_data.op    = op;
    req_data.addr  = addr;
    req_data.wdata = wdata;
    @(negedge clk);
    req      = 1'b0;
    last_lat = 1;
    if (busy !== 1'b1) report_mismatch("busy", 32'(busy), 32'h1, addr);
    while (resp_valid !== 1'b1) begin
      @(negedge clk);
      last_lat++;
    end
    last_resp = resp_data;
    if (resp_data.hit !== e.hit) begin
      report_mismatch("resp_data.hit", 32'(resp_data.hit), 32'(e.hit), addr);
    end
    if (resp_data.rdata !== e.rdata) begin
      report_mismatch("resp_data.rdata", resp_data.rdata, e.rdata, addr);
    end
    if (rd_cnt != int'(e.rd)) report_mismatch("mem_rd count", 32'(rd_cnt), 32'(e.rd), addr);
    if (wr_cnt != int'(e.wb)) report_mismatch("mem_wr count", 32'(wr_cnt), 32'(e.wb), addr);
  endtask

  // --------------------------------------------------
  // Memory model and command compare
  // --------------------------------------------------
  initial begin
    int          wait_cnt;
    bit          cmd_rd;
    logic [31:0] cmd_addr;
    logic [31:0] cmd_data;
    wait_cnt  = 0;
    cmd_rd    = 1'b0;
    cmd_addr  = '0;
    cmd_data  = '0;
    mem_ack   = 1'b0;
    mem_rdata = '0;
    forever begin
      @(negedge clk);
      mem_ack = 1'b0;
      if (wait_cnt > 0) begin
        wait_cnt--;
        if (wait_cnt == 0) begin
          mem_ack = 1'b1;
          if (cmd_rd) begin
            mem_rdata = mem_model.exists(cmd_addr) ? mem_model[cmd_addr]
                                                   : unwritten_word(cmd_addr);
          end else begin
            mem_model[cmd_addr] = cmd_data;
          end
        end
      end
      if (mem_rd === 1'b1 || mem_wr === 1'b1) begin
        if (wait_cnt != 0) begin
          $display("A memory command was issued while another one was still open.");
          err_cnt++;
        end
        cmd_rd   = (mem_rd === 1'b1);
        cmd_addr = mem_req.addr;
        cmd_data = mem_req.wdata;
        wait_cnt = 1 + int'($unsigned($random(seed)) % 4);
      end
    end
  end

  initial begin
    forever begin
      @(negedge clk);
      if (mem_wr === 1'b1) begin
        wr_cnt++;
        if (!exp_q.wb) begin
          $display("Unexpected write-back to %h with no dirty victim.", mem_req.addr);
          err_cnt++;
        end else begin
          if (mem_req.addr !== exp_q.wb_addr) begin
            report_mismatch("mem_req.addr", mem_req.addr, exp_q.wb_addr, exp_q.wb_addr);
          end
          if (mem_req.wdata !== exp_q.wb_data) begin
            report_mismatch("mem_req.wdata", mem_req.wdata, exp_q.wb_data, exp_q.wb_addr);
          end
        end
      end
      if (mem_rd === 1'b1) begin
        rd_cnt++;
        if (!exp_q.rd) begin
          $display("Unexpected memory read from %h.", mem_req.addr);
          err_cnt++;
        end else begin
          if (exp_q.wb && wr_cnt == 0) begin
            $display("The refill read from %h came before the write-back.", mem_req.addr);
            err_cnt++;
          end
          if (mem_req.addr !== exp_q.rd_addr) begin
            report_mismatch("mem_req.addr", mem_req.addr, exp_q.rd_addr, exp_q.rd_addr);
          end
        end
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("The run timed out after %0d ns before all tests finished.", WATCHDOG_NS);
    $display("SIMULATION FAILED");
    $finish;
  end

  // --------------------------------------------------
  // Tests
  // --------------------------------------------------
  initial begin
    int                   errs;
    int                   init_cycles;
    bit                   quiet;
    cache_pkg::cache_op_e op;
    logic [31:0]          addr;
    logic [31:0]          wdata;
    seed     = 54722;
    arst_n   = 1'b0;
    req      = 1'b0;
    req_data = '0;
    quiet    = 1'b1;
    repeat (5) @(negedge clk);

    errs = err_cnt;
    if (busy !== 1'b1) report_mismatch("busy", 32'(busy), 32'h1, 32'h0);
    arst_n      = 1'b1;
    init_cycles = 0;
    while (busy === 1'b1) begin
      if (resp_valid !== 1'b0 || mem_rd !== 1'b0 || mem_wr !== 1'b0) quiet = 1'b0;
      @(negedge clk);
      init_cycles++;
    end
    if (!quiet) begin
      $display("resp_valid, mem_rd or mem_wr was active during the init sweep.");
      err_cnt++;
    end
    if (init_cycles < 256 || init_cycles > 258) begin
      $display("busy fell after %0d cycles, but the sweep covers 256 sets.", init_cycles);
      err_cnt++;
    end
    run_access(cache_pkg::OP_LOAD, ADDR_X, 32'h0);
    if (last_resp.hit !== 1'b0) begin
      report_mismatch("resp_data.hit", 32'(last_resp.hit), 32'h0, ADDR_X);
    end
    if (last_resp.rdata !== (ADDR_X ^ 32'hA5A5_0000)) begin
      report_mismatch("resp_data.rdata", last_resp.rdata, ADDR_X ^ 32'hA5A5_0000, ADDR_X);
    end
    if (rd_cnt != 1) report_mismatch("mem_rd count", 32'(rd_cnt), 32'h1, ADDR_X);
    close_test("1 init sweep and first load miss", errs);

    errs = err_cnt;
    run_access(cache_pkg::OP_LOAD, ADDR_X, 32'h0);
    if (last_resp.hit !== 1'b1) begin
      report_mismatch("resp_data.hit", 32'(last_resp.hit), 32'h1, ADDR_X);
    end
    if (last_lat != 2) report_mismatch("resp_valid latency", 32'(last_lat), 32'h2, ADDR_X);
    if (rd_cnt + wr_cnt != 0) begin
      report_mismatch("memory commands", 32'(rd_cnt + wr_cnt), 32'h0, ADDR_X);
    end
    close_test("2 load hit latency", errs);

    errs = err_cnt;
    run_access(cache_pkg::OP_STORE, ADDR_X, 32'h1357_9BDF);
    run_access(cache_pkg::OP_LOAD, ADDR_X, 32'h0);
    if (last_resp.hit !== 1'b1) begin
      report_mismatch("resp_data.hit", 32'(last_resp.hit), 32'h1, ADDR_X);
    end
    if (last_resp.rdata !== 32'h1357_9BDF) begin
      report_mismatch("resp_data.rdata", last_resp.rdata, 32'h1357_9BDF, ADDR_X);
    end
    if (rd_cnt + wr_cnt != 0) begin
      report_mismatch("memory commands", 32'(rd_cnt + wr_cnt), 32'h0, ADDR_X);
    end
    close_test("3 store then load hit", errs);

    errs = err_cnt;
    run_access(cache_pkg::OP_STORE, ADDR_A, 32'hC0DE_1234);
    run_access(cache_pkg::OP_LOAD, ADDR_B, 32'h0);  // Evicts the dirty line of ADDR_A.
    if (wr_cnt != 1) report_mismatch("mem_wr count", 32'(wr_cnt), 32'h1, ADDR_B);
    if (rd_cnt != 1) report_mismatch("mem_rd count", 32'(rd_cnt), 32'h1, ADDR_B);
    run_access(cache_pkg::OP_LOAD, ADDR_A, 32'h0);
    if (last_resp.rdata !== 32'hC0DE_1234) begin
      report_mismatch("resp_data.rdata", last_resp.rdata, 32'hC0DE_1234, ADDR_A);
    end
    close_test("4 dirty eviction and reload", errs);

    errs = err_cnt;
    for (int i = 0; i < RAND_OPS; i++) begin
      op    = ($random(seed) & 1) ? cache_pkg::OP_STORE : cache_pkg::OP_LOAD;
      addr  = RAND_BASE + ($random(seed) & 32'h0000_0FFC);  // 4 tags share each set.
      wdata = $random(seed);
      run_access(op, addr, wdata);
    end
    close_test("5 random loads and stores", errs);

    $display("Tests passed: %0d, tests failed: %0d, errors: %0d",
             tests_passed, tests_failed, err_cnt);
    if (tests_failed == 0 && err_cnt == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

//--- src.f
hw/cache_pkg.sv
hw/bram.sv
hw/direct_map.sv
hw/cache_ctrl.sv
hw/cache_top.sv
verification/tb_cache.sv

//--- run_sim.sh
#!/bin/sh
# Builds the cache testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_cache -f src.f -o tb_cache
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/tb_cache)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -q '^SIMULATION PASSED$'; then
  exit 0
fi
exit 1
